// File: verilog/nn_defs.svh
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// pixels per input vector, a multiple of NN_LANES
`define NN_INPUTS 20

// pixels delivered per beat
`define NN_LANES 5

// neurons in the hidden layer
`define NN_NEURONS 4

`define NN_BEATS (`NN_INPUTS / `NN_LANES)

// weight address, covers bias plus NN_INPUTS weights
`define NN_WSEL_W 5
`define NN_PSEL_W 5
`define NN_NSEL_W 2

`endif

// File: verilog/nn_pkg.sv
package nn_pkg;

  // unsigned input pixel
  typedef logic [7:0] pixel_t;

  // signed weight, also used for the bias
  typedef logic signed [15:0] weight_t;

  // running dot product
  typedef logic signed [31:0] accum_t;

  typedef logic [7:0] lut_idx_t;

  // sign in bit 8, tanh magnitude in bits 7:0
  typedef logic [8:0] act_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCUMULATE,
    EVALUATE
  } neuron_state_e;

  typedef enum logic [1:0] {
    F_IDLE,
    F_LOAD,
    F_STREAM
  } feeder_state_e;

endpackage

// File: verilog/tanh_lut.sv
`timescale 1ns/10ps

module tanh_lut (
  input  nn_pkg::lut_idx_t idx,
  output nn_pkg::pixel_t   mag
);

  // one 8-bit entry per index value
  typedef logic [255:0][7:0] table_t;

  // entry m holds 255*tanh(m/64), from the rational form
  // x*(27+x^2)/(27+9*x^2) with x = m/64 scaled to integers
  function automatic table_t build_table();
    table_t t;
    longint num;
    longint den;
    longint v;
    for (int m = 0; m < 256; m++) begin
      num = 64'd255 * m * (64'd110592 + m * m);
      den = 64'd64 * (64'd110592 + 9 * m * m);
      v = num / den;
      // top of the range overshoots slightly
      if (v > 255) begin
        v = 255;
      end
      t[m] = 8'(v);
    end
    return t;
  endfunction

  localparam table_t TANH_TABLE = build_table();

  assign mag = TANH_TABLE[idx];

endmodule

// File: verilog/neuron.sv
`timescale 1ns/10ps
`include "nn_defs.svh"

module neuron (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wt_wr,
  input  logic [`NN_WSEL_W-1:0] weight_sel,
  input  nn_pkg::weight_t       weight_d,
  input  logic                  z,
  input  logic                  en,
  input  nn_pkg::pixel_t        d_0,
  input  nn_pkg::pixel_t        d_1,
  input  nn_pkg::pixel_t        d_2,
  input  nn_pkg::pixel_t        d_3,
  input  nn_pkg::pixel_t        d_4,
  output nn_pkg::act_t          q,
  output logic                  q_valid
);

  // bias at index 0, weight for pixel i at index i+1
  nn_pkg::weight_t weights [`NN_INPUTS+1];

  nn_pkg::neuron_state_e state;
  nn_pkg::accum_t        accum;
  nn_pkg::accum_t        beat_sum;
  logic [`NN_WSEL_W-1:0] beat;
  logic [`NN_WSEL_W-1:0] base;
  logic [31:0]           accum_abs;
  nn_pkg::lut_idx_t      lut_idx;
  nn_pkg::pixel_t        lut_mag;

  // pixel is unsigned, so zero-extend before the signed multiply
  function automatic nn_pkg::accum_t mac(nn_pkg::pixel_t p, nn_pkg::weight_t wt);
    nn_pkg::accum_t pe;
    nn_pkg::accum_t we;
    pe = nn_pkg::accum_t'($signed({1'b0, p}));
    we = nn_pkg::accum_t'(wt);
    return pe * we;
  endfunction

  tanh_lut i_tanh_lut (
    .idx (lut_idx),
    .mag (lut_mag)
  );

  // weights of the current beat start right after base
  assign base = `NN_WSEL_W'(beat * `NN_LANES);

  assign beat_sum = mac(d_0, weights[base + 1]) +
                    mac(d_1, weights[base + 2]) +
                    mac(d_2, weights[base + 3]) +
                    mac(d_3, weights[base + 4]) +
                    mac(d_4, weights[base + 5]);

  // two's complement magnitude, 32'h8000_0000 stays correct as unsigned
  assign accum_abs = accum[31] ? -accum : accum;

  // anything at or above 1024 clips to the last entry
  assign lut_idx = (|accum_abs[31:10]) ? 8'hff : accum_abs[9:2];

  // writes only land while idle, a start strobe wins over a write
  always_ff @(posedge clk) begin
    if (wt_wr && state == nn_pkg::IDLE && !z && weight_sel <= `NN_INPUTS) begin
      weights[weight_sel] <= weight_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state == nn_pkg::IDLE && z) begin
      accum <= weights[0];
    end else if (state == nn_pkg::ACCUMULATE && en) begin
      accum <= accum + beat_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= nn_pkg::IDLE;
      beat    <= '0;
      q       <= '0;
      q_valid <= 1'b0;
    end else begin
      q_valid <= 1'b0;
      case (state)
        nn_pkg::IDLE: begin
          if (z) begin
            beat  <= '0;
            state <= nn_pkg::ACCUMULATE;
          end
        end
        nn_pkg::ACCUMULATE: begin
          if (en) begin
            beat <= beat + 1'b1;
          end else begin
            state <= nn_pkg::EVALUATE;
          end
        end
        nn_pkg::EVALUATE: begin
          q       <= {accum[31], lut_mag};
          q_valid <= 1'b1;
          state   <= nn_pkg::IDLE;
        end
        default: begin
          state <= nn_pkg::IDLE;
        end
      endcase
    end
  end

  // feeder only streams after z has moved us out of IDLE
  a_no_en_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state == nn_pkg::IDLE) |-> !en
  );

  a_beat_range: assert property (
    @(posedge clk) disable iff (!rst_n) beat <= `NN_BEATS
  );

endmodule

// File: verilog/pixel_feeder.sv
`timescale 1ns/10ps
`include "nn_defs.svh"

module pixel_feeder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pix_wr,
  input  logic [`NN_PSEL_W-1:0] pix_addr,
  input  nn_pkg::pixel_t        pix_d,
  input  logic                  start,
  input  logic                  done,
  output logic                  z,
  output logic                  en,
  output nn_pkg::pixel_t        d_0,
  output nn_pkg::pixel_t        d_1,
  output nn_pkg::pixel_t        d_2,
  output nn_pkg::pixel_t        d_3,
  output nn_pkg::pixel_t        d_4,
  output logic                  busy
);

  nn_pkg::pixel_t        pix_buf [`NN_INPUTS];
  nn_pkg::feeder_state_e state;
  logic [`NN_PSEL_W-1:0] beat;
  logic [`NN_PSEL_W-1:0] base;
  logic                  accept;

  // drops in the same cycle the neurons report done
  assign busy   = (state != nn_pkg::F_IDLE) && !done;
  assign accept = start && !busy;

  always_ff @(posedge clk) begin
    if (pix_wr && !busy && pix_addr < `NN_INPUTS) begin
      pix_buf[pix_addr] <= pix_d;
    end
  end

  // lane k of beat b carries pixel b*NN_LANES+k
  assign base = `NN_PSEL_W'(beat * `NN_LANES);
  assign d_0  = pix_buf[base];
  assign d_1  = pix_buf[base + 1];
  assign d_2  = pix_buf[base + 2];
  assign d_3  = pix_buf[base + 3];
  assign d_4  = pix_buf[base + 4];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= nn_pkg::F_IDLE;
      z     <= 1'b0;
      en    <= 1'b0;
      beat  <= '0;
    end else begin
      z <= 1'b0;
      if (accept) begin
        z     <= 1'b1;
        state <= nn_pkg::F_LOAD;
      end else begin
        case (state)
          nn_pkg::F_LOAD: begin
            en    <= 1'b1;
            beat  <= '0;
            state <= nn_pkg::F_STREAM;
          end
          nn_pkg::F_STREAM: begin
            if (en) begin
              // hold beat on the last one so the lanes stay in range
              if (beat == `NN_BEATS - 1) begin
                en <= 1'b0;
              end else begin
                beat <= beat + 1'b1;
              end
            end else if (done) begin
              state <= nn_pkg::F_IDLE;
            end
          end
          default: begin
            state <= nn_pkg::F_IDLE;
          end
        endcase
      end
    end
  end

  // bias load and data beats never overlap
  a_z_en_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(z && en)
  );

endmodule

// File: verilog/hidden_layer.sv
`timescale 1ns/10ps
`include "nn_defs.svh"

module hidden_layer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pix_wr,
  input  logic [`NN_PSEL_W-1:0] pix_addr,
  input  nn_pkg::pixel_t        pix_d,
  input  logic                  wt_wr,
  input  logic [`NN_NSEL_W-1:0] neuron_sel,
  input  logic [`NN_WSEL_W-1:0] weight_sel,
  input  nn_pkg::weight_t       weight_d,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output nn_pkg::act_t          act_0,
  output nn_pkg::act_t          act_1,
  output nn_pkg::act_t          act_2,
  output nn_pkg::act_t          act_3
);

  logic                   z;
  logic                   en;
  nn_pkg::pixel_t         d_0;
  nn_pkg::pixel_t         d_1;
  nn_pkg::pixel_t         d_2;
  nn_pkg::pixel_t         d_3;
  nn_pkg::pixel_t         d_4;
  logic [`NN_NEURONS-1:0] q_valid;
  nn_pkg::act_t           act [`NN_NEURONS];

  pixel_feeder i_pixel_feeder (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_wr   (pix_wr),
    .pix_addr (pix_addr),
    .pix_d    (pix_d),
    .start    (start),
    .done     (done),
    .z        (z),
    .en       (en),
    .d_0      (d_0),
    .d_1      (d_1),
    .d_2      (d_2),
    .d_3      (d_3),
    .d_4      (d_4),
    .busy     (busy)
  );

  for (genvar i = 0; i < `NN_NEURONS; i++) begin : g_neuron
    logic wt_wr_n;

    // only the addressed neuron sees the write, and none while busy
    assign wt_wr_n = wt_wr && !busy && (neuron_sel == `NN_NSEL_W'(i));

    neuron i_neuron (
      .clk        (clk),
      .rst_n      (rst_n),
      .wt_wr      (wt_wr_n),
      .weight_sel (weight_sel),
      .weight_d   (weight_d),
      .z          (z),
      .en         (en),
      .d_0        (d_0),
      .d_1        (d_1),
      .d_2        (d_2),
      .d_3        (d_3),
      .d_4        (d_4),
      .q          (act[i]),
      .q_valid    (q_valid[i])
    );
  end

  // all neurons run in lockstep, neuron 0 speaks for the layer
  assign done  = q_valid[0];
  assign act_0 = act[0];
  assign act_1 = act[1];
  assign act_2 = act[2];
  assign act_3 = act[3];

endmodule

// File: dv/tb_hidden_layer.sv
`timescale 1ns/10ps
`include "nn_defs.svh"

module tb_hidden_layer;

  localparam int NUM_TESTS = 26;
  localparam int EVAL_CYCLES = `NN_BEATS + 4;

  logic                  clk;
  logic                  rst_n;
  logic                  pix_wr;
  logic [`NN_PSEL_W-1:0] pix_addr;
  nn_pkg::pixel_t        pix_d;
  logic                  wt_wr;
  logic [`NN_NSEL_W-1:0] neuron_sel;
  logic [`NN_WSEL_W-1:0] weight_sel;
  nn_pkg::weight_t       weight_d;
  logic                  start;
  logic                  busy;
  logic                  done;
  nn_pkg::act_t          act_0;
  nn_pkg::act_t          act_1;
  nn_pkg::act_t          act_2;
  nn_pkg::act_t          act_3;

  // model of what has been written into the DUT
  int           pix_mem [`NN_INPUTS];
  int           wt_mem [`NN_NEURONS][`NN_INPUTS+1];
  logic [8:0]   exp_act [`NN_NEURONS];
  logic [8:0]   got_act [`NN_NEURONS];
  string        test_name;
  logic [31:0]  lfsr_state;
  int           done_count;
  int           evals_run;

  hidden_layer i_hidden_layer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_wr     (pix_wr),
    .pix_addr   (pix_addr),
    .pix_d      (pix_d),
    .wt_wr      (wt_wr),
    .neuron_sel (neuron_sel),
    .weight_sel (weight_sel),
    .weight_d   (weight_d),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .act_0      (act_0),
    .act_1      (act_1),
    .act_2      (act_2),
    .act_3      (act_3)
  );

  assign got_act[0] = act_0;
  assign got_act[1] = act_1;
  assign got_act[2] = act_2;
  assign got_act[3] = act_3;

  always #20 clk = ~clk;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int tanh_ref(int m);
    longint v;
    v = (64'd255 * m * (64'd110592 + m * m)) / (64'd64 * (64'd110592 + 9 * m * m));
    return (v > 255) ? 255 : int'(v);
  endfunction

  // bias plus dot product, then magnitude, clip, table and sign
  function automatic logic [8:0] ref_act(int n);
    longint sum;
    longint mag;
    int     idx;
    sum = wt_mem[n][0];
    for (int i = 0; i < `NN_INPUTS; i++) begin
      sum += longint'(pix_mem[i]) * wt_mem[n][i+1];
    end
    mag = (sum < 0) ? -sum : sum;
    idx = (mag >= 1024) ? 255 : int'(mag / 4);
    return {sum < 0, 8'(tanh_ref(idx))};
  endfunction

  task automatic write_pixel(int addr, int val);
    pix_wr = 1'b1;
    pix_addr = `NN_PSEL_W'(addr);
    pix_d = 8'(val);
    @(negedge clk);
    pix_wr = 1'b0;
  endtask

  task automatic write_weight(int n, int sel, int val);
    wt_wr = 1'b1;
    neuron_sel = `NN_NSEL_W'(n);
    weight_sel = `NN_WSEL_W'(sel);
    weight_d = 16'(val);
    @(negedge clk);
    wt_wr = 1'b0;
  endtask

  task automatic load_layer();
    for (int i = 0; i < `NN_INPUTS; i++) begin
      write_pixel(i, pix_mem[i]);
    end
    for (int n = 0; n < `NN_NEURONS; n++) begin
      for (int w = 0; w <= `NN_INPUTS; w++) begin
        write_weight(n, w, wt_mem[n][w]);
      end
    end
  endtask

  task automatic randomize_layer();
    for (int i = 0; i < `NN_INPUTS; i++) begin
      pix_mem[i] = int'(take_bits(8));
    end
    for (int n = 0; n < `NN_NEURONS; n++) begin
      for (int w = 0; w <= `NN_INPUTS; w++) begin
        wt_mem[n][w] = int'($signed(16'(take_bits(16))));
      end
    end
  endtask

  // mode 1 pulses a second start while busy, mode 2 a weight write
  task automatic run_eval(string name, int mode);
    int cycles;
    for (int n = 0; n < `NN_NEURONS; n++) begin
      exp_act[n] = ref_act(n);
    end
    test_name = name;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 1;
    while (!done) begin
      assert (busy) else abort_run($sformatf("%s: busy low in cycle %0d", name, cycles));
      if (cycles == 3 && mode == 1) begin
        start = 1'b1;
      end
      if (cycles == 3 && mode == 2) begin
        wt_wr = 1'b1;
        neuron_sel = 2'd2;
        weight_sel = 5'd5;
        weight_d = 16'(~wt_mem[2][5]);
      end
      @(negedge clk);
      start = 1'b0;
      wt_wr = 1'b0;
      cycles++;
    end
    assert (cycles == EVAL_CYCLES) else
      abort_run($sformatf("FAIL %s latency: expected %0d, actual %0d", name, EVAL_CYCLES, cycles));
    assert (!busy) else abort_run($sformatf("%s: busy still high with done", name));
    @(negedge clk);
    evals_run++;
    if (mode == 1) begin
      repeat (EVAL_CYCLES) begin
        assert (!done) else abort_run($sformatf("%s: ignored start produced a done", name));
        @(negedge clk);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && done) begin
      done_count++;
      for (int n = 0; n < `NN_NEURONS; n++) begin
        assert (got_act[n] == exp_act[n]) else
          abort_run($sformatf("FAIL %s act_%0d: expected %03h, actual %03h",
                              test_name, n, exp_act[n], got_act[n]));
      end
    end
  end

  initial begin
    repeat (NUM_TESTS * (`NN_INPUTS * (`NN_NEURONS + 1) + 20)) @(posedge clk);
    abort_run("timeout: the tests did not finish in the allowed number of cycles");
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    pix_wr = 1'b0;
    pix_addr = '0;
    pix_d = '0;
    wt_wr = 1'b0;
    neuron_sel = '0;
    weight_sel = '0;
    weight_d = '0;
    start = 1'b0;
    lfsr_state = 32'h18c3;
    done_count = 0;
    evals_run = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // zero weights, so only the bias reaches the table
    randomize_layer();
    for (int n = 0; n < `NN_NEURONS; n++) begin
      for (int w = 1; w <= `NN_INPUTS; w++) begin
        wt_mem[n][w] = 0;
      end
    end
    wt_mem[0][0] = 100;
    wt_mem[1][0] = -300;
    wt_mem[2][0] = 700;
    wt_mem[3][0] = -1000;
    load_layer();
    run_eval("bias_only", 0);

    for (int t = 0; t < 20; t++) begin
      randomize_layer();
      load_layer();
      run_eval($sformatf("random_%0d", t), 0);
    end

    // extreme weights, sign alternating per neuron, then flipped
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < `NN_INPUTS; i++) begin
        pix_mem[i] = 200 + i;
      end
      for (int n = 0; n < `NN_NEURONS; n++) begin
        wt_mem[n][0] = 0;
        for (int w = 1; w <= `NN_INPUTS; w++) begin
          wt_mem[n][w] = ((n + t) % 2 == 0) ? 32767 : -32768;
        end
      end
      load_layer();
      run_eval($sformatf("saturate_%0d", t), 0);
    end

    // neuron 2 sums to zero so a stray write at index 5 shows up
    randomize_layer();
    for (int w = 0; w <= `NN_INPUTS; w++) begin
      wt_mem[2][w] = 0;
    end
    pix_mem[4] = 255;
    load_layer();
    run_eval("start_while_busy", 1);
    run_eval("weight_write_while_busy", 2);
    run_eval("after_busy_write", 0);

    if (done_count == evals_run) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run($sformatf("%0d done strobes seen for %0d evaluations", done_count, evals_run));
    end
  end

endmodule

// File: tb.f
+incdir+verilog
verilog/nn_pkg.sv
verilog/tanh_lut.sv
verilog/neuron.sv
verilog/pixel_feeder.sv
verilog/hidden_layer.sv
dv/tb_hidden_layer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the hidden layer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_hidden_layer -o sim_tb &&
./obj_dir/sim_tb | grep -F "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
